// File: src/imu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// Shared constants and types for the accelerometer reader
// Register map follows the usual 6-axis SPI sensor layout
// Warm-up, load and hold counts are defaults only
//~~~~~~~~~~~~~~~~~~~~

package imu_pkg;

  // Register addresses and configuration value
  localparam logic [7:0] REG_ACC_CONFIG   = 8'h1C;
  localparam logic [7:0] ACC_CONFIG_VALUE = 8'h08;
  localparam logic [7:0] REG_WHO_AM_I     = 8'h75;
  localparam logic [7:0] REG_ACC_XOUT_H   = 8'h3B;

  // Address bit 7 set means read
  localparam logic       SPI_READ_BIT     = 1'b1;
  // Clocked out while reading
  localparam logic [7:0] DUMMY_BYTE       = 8'hFF;

  // X, Y, Z high and low bytes
  localparam int ACC_BURST_BYTES = 6;

  // clk cycles per SCLK half period
  localparam int SPI_HALF_PERIOD = 4;

  // Power-up timing in clk cycles
  localparam int unsigned WARMUP_CYCLES_DEFAULT = 2**26;
  localparam int unsigned LOAD_CYCLES_DEFAULT   = 2**16;
  localparam int unsigned HOLD_CYCLES_DEFAULT   = 2**8;

  // Also the initial credit count of the sequencer
  localparam int SAMPLE_FIFO_DEPTH = 4;

  // Burst bytes as received, byte 5 arrives first
  typedef logic [5:0][7:0] acc_raw_t;

  // One accelerometer reading
  typedef struct packed {
    logic signed [15:0] x;
    logic signed [15:0] y;
    logic signed [15:0] z;
  } acc_sample_t;

  // One byte request to the SPI engine
  typedef struct packed {
    logic [7:0] tx_byte;
    // Pull chip select low before this byte
    logic       first;
    // Release chip select after this byte
    logic       last;
  } spi_req_t;

endpackage

// File: src/spi_byte_master.sv
//~~~~~~~~~~~~~~~~~~~~
// SPI mode 0 master, one byte per start, MSB first
// Chip select spans all bytes from first to last
// busy stays high for two half periods after a last byte
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module spi_byte_master (
  input  logic               clk,
  input  logic               rst,
  input  imu_pkg::spi_req_t  req,
  input  logic               start,
  input  logic               miso,
  output logic               mosi,
  output logic               sclk,
  output logic               ss,
  output logic               busy,
  output logic               done,
  output logic [7:0]         rx_byte
);

  import imu_pkg::*;

  localparam int DIV_W = $clog2(SPI_HALF_PERIOD);

  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       half_cnt;
  logic             tail;
  logic             last_q;
  logic [7:0]       tx_shift;
  logic [7:0]       rx_shift;
  logic             div_end;

  // End of one SCLK half period
  assign div_end = (div_cnt == DIV_W'(SPI_HALF_PERIOD - 1));

  // Idle line low, shift register MSB otherwise
  assign mosi    = busy & ~tail & tx_shift[7];
  assign rx_byte = rx_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      tail     <= 1'b0;
      done     <= 1'b0;
      sclk     <= 1'b0;
      ss       <= 1'b1;
      div_cnt  <= '0;
      half_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy     <= 1'b1;
          div_cnt  <= '0;
          half_cnt <= '0;
          last_q   <= req.last;
          tx_shift <= req.tx_byte;
          // Open a new frame
          if (req.first) begin
            ss <= 1'b0;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
        if (div_end) begin
          div_cnt  <= '0;
          half_cnt <= half_cnt + 1'b1;
          if (tail) begin
            // Two half periods of margin before ss rises
            if (half_cnt == 4'd1) begin
              ss   <= 1'b1;
              busy <= 1'b0;
              tail <= 1'b0;
            end
          end else begin
            sclk <= ~sclk;
            // Rising edge samples, falling edge shifts
            if (!sclk) begin
              rx_shift <= {rx_shift[6:0], miso};
            end else begin
              tx_shift <= {tx_shift[6:0], 1'b0};
            end
            // Sixteen half periods make one byte
            if (half_cnt == 4'd15) begin
              done     <= 1'b1;
              half_cnt <= '0;
              if (last_q) begin
                tail <= 1'b1;
              end else begin
                busy <= 1'b0;
              end
            end
          end
        end
      end
    end
  end

endmodule

// File: src/imu_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~
// Power-up, config write, identity read, then burst reads
// Counts must be at least 1
// Ticks outside idle or without credit are dropped
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module imu_sequencer #(
  parameter int unsigned WARMUP_CYCLES = imu_pkg::WARMUP_CYCLES_DEFAULT,
  parameter int unsigned LOAD_CYCLES   = imu_pkg::LOAD_CYCLES_DEFAULT,
  parameter int unsigned HOLD_CYCLES   = imu_pkg::HOLD_CYCLES_DEFAULT
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               sample_tick,
  output imu_pkg::spi_req_t  spi_req,
  output logic               spi_start,
  input  logic               spi_busy,
  input  logic               spi_done,
  input  logic [7:0]         spi_rx,
  output logic               push,
  output imu_pkg::acc_raw_t  push_data,
  input  logic               credit_return,
  output logic [7:0]         imu_id,
  output logic               id_valid
);

  import imu_pkg::*;

  localparam int CREDIT_W = $clog2(SAMPLE_FIFO_DEPTH + 1);

  typedef enum logic [2:0] {
    S_WARMUP,
    S_CFG,
    S_LOAD,
    S_ID,
    S_HOLD,
    S_IDLE,
    S_BURST
  } state_t;

  state_t              state;
  logic [31:0]         wait_cnt;
  logic [2:0]          byte_cnt;
  logic                pending;
  logic [CREDIT_W-1:0] credits;

  // Byte request for the current state and position
  always_comb begin
    spi_req         = '0;
    spi_req.tx_byte = DUMMY_BYTE;
    spi_req.first   = (byte_cnt == 3'd0);
    case (state)
      S_CFG: begin
        spi_req.tx_byte = (byte_cnt == 3'd0) ? REG_ACC_CONFIG : ACC_CONFIG_VALUE;
        spi_req.last    = (byte_cnt == 3'd1);
      end
      S_ID: begin
        if (byte_cnt == 3'd0) begin
          spi_req.tx_byte = {SPI_READ_BIT, REG_WHO_AM_I[6:0]};
        end
        spi_req.last = (byte_cnt == 3'd1);
      end
      S_BURST: begin
        if (byte_cnt == 3'd0) begin
          spi_req.tx_byte = {SPI_READ_BIT, REG_ACC_XOUT_H[6:0]};
        end
        // Address plus six data bytes
        spi_req.last = (byte_cnt == 3'(ACC_BURST_BYTES));
      end
      default: begin
        spi_req.first = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_WARMUP;
      wait_cnt  <= '0;
      byte_cnt  <= '0;
      pending   <= 1'b0;
      spi_start <= 1'b0;
      push      <= 1'b0;
      id_valid  <= 1'b0;
    end else begin
      spi_start <= 1'b0;
      push      <= 1'b0;
      case (state)
        S_WARMUP: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == WARMUP_CYCLES - 1) begin
            wait_cnt <= '0;
            state    <= S_CFG;
          end
        end
        S_LOAD: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == LOAD_CYCLES - 1) begin
            wait_cnt <= '0;
            state    <= S_ID;
          end
        end
        S_HOLD: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == HOLD_CYCLES - 1) begin
            wait_cnt <= '0;
            state    <= S_IDLE;
          end
        end
        S_IDLE: begin
          // Only start a burst that has room downstream
          if (sample_tick && credits != '0) begin
            state <= S_BURST;
          end
        end
        default: begin
          // Byte transfer states share one handshake
          if (!pending && !spi_busy) begin
            spi_start <= 1'b1;
            pending   <= 1'b1;
          end
          if (spi_done) begin
            pending  <= 1'b0;
            byte_cnt <= byte_cnt + 1'b1;
            if (state == S_BURST && byte_cnt != 3'd0) begin
              push_data <= {push_data[4:0], spi_rx};
            end
            if (spi_req.last) begin
              byte_cnt <= '0;
              case (state)
                S_CFG: state <= S_LOAD;
                S_ID: begin
                  imu_id   <= spi_rx;
                  id_valid <= 1'b1;
                  state    <= S_HOLD;
                end
                default: begin
                  // Full sample now sits in push_data
                  push  <= 1'b1;
                  state <= S_HOLD;
                end
              endcase
            end
          end
        end
      endcase
    end
  end

  // One credit per free FIFO slot
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CREDIT_W'(SAMPLE_FIFO_DEPTH);
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// File: src/sample_fifo.sv
//~~~~~~~~~~~~~~~~~~~~
// Raw sample buffer, no full flag
// Writer must hold a credit per push
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sample_fifo #(
  parameter int DEPTH = imu_pkg::SAMPLE_FIFO_DEPTH
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               push,
  input  imu_pkg::acc_raw_t  push_data,
  input  logic               pop,
  output imu_pkg::acc_raw_t  head,
  output logic               empty,
  output logic               credit_return
);

  import imu_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  acc_raw_t   mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  assign empty  = (count == '0);
  // Pops on an empty buffer are ignored
  assign do_pop = pop & ~empty;
  assign head   = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      // Each freed slot goes back as one credit
      credit_return <= do_pop;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/sample_publisher.sv
//~~~~~~~~~~~~~~~~~~~~
// Host output register under valid/ready
// Axes are big-endian 16-bit two's complement
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sample_publisher (
  input  logic                  clk,
  input  logic                  rst,
  input  imu_pkg::acc_raw_t     head,
  input  logic                  empty,
  output logic                  pop,
  output imu_pkg::acc_sample_t  sample,
  output logic                  sample_valid,
  input  logic                  sample_ready
);

  logic can_load;

  // Register empty or emptying this cycle
  assign can_load = ~sample_valid | sample_ready;
  assign pop      = can_load & ~empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      sample_valid <= 1'b0;
    end else if (can_load) begin
      sample_valid <= ~empty;
    end
  end

  // Held while waiting on the host
  always_ff @(posedge clk) begin
    if (pop) begin
      // High byte first for each axis
      sample.x <= head[5:4];
      sample.y <= head[3:2];
      sample.z <= head[1:0];
    end
  end

endmodule

// File: src/imu_reader.sv
//~~~~~~~~~~~~~~~~~~~~
// Accelerometer reader top, SPI in, samples out
// Counts are in clk cycles, shorten them for simulation
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module imu_reader #(
  parameter int unsigned WARMUP_CYCLES = imu_pkg::WARMUP_CYCLES_DEFAULT,
  parameter int unsigned LOAD_CYCLES   = imu_pkg::LOAD_CYCLES_DEFAULT,
  parameter int unsigned HOLD_CYCLES   = imu_pkg::HOLD_CYCLES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sample_tick,
  input  logic                  imu_miso,
  output logic                  imu_mosi,
  output logic                  imu_sclk,
  output logic                  imu_ss,
  output imu_pkg::acc_sample_t  sample,
  output logic                  sample_valid,
  input  logic                  sample_ready,
  output logic [7:0]            imu_id,
  output logic                  id_valid
);

  import imu_pkg::*;

  spi_req_t   spi_req;
  logic       spi_start;
  logic       spi_busy;
  logic       spi_done;
  logic [7:0] spi_rx;
  logic       push;
  acc_raw_t   push_data;
  logic       credit_return;
  logic       pop;
  acc_raw_t   head;
  logic       empty;

  // Producer control
  imu_sequencer #(
    .WARMUP_CYCLES (WARMUP_CYCLES),
    .LOAD_CYCLES   (LOAD_CYCLES),
    .HOLD_CYCLES   (HOLD_CYCLES)
  ) i_sequencer (
    .clk           (clk),
    .rst           (rst),
    .sample_tick   (sample_tick),
    .spi_req       (spi_req),
    .spi_start     (spi_start),
    .spi_busy      (spi_busy),
    .spi_done      (spi_done),
    .spi_rx        (spi_rx),
    .push          (push),
    .push_data     (push_data),
    .credit_return (credit_return),
    .imu_id        (imu_id),
    .id_valid      (id_valid)
  );

  // Sensor bus
  spi_byte_master i_spi (
    .clk     (clk),
    .rst     (rst),
    .req     (spi_req),
    .start   (spi_start),
    .miso    (imu_miso),
    .mosi    (imu_mosi),
    .sclk    (imu_sclk),
    .ss      (imu_ss),
    .busy    (spi_busy),
    .done    (spi_done),
    .rx_byte (spi_rx)
  );

  sample_fifo #(
    .DEPTH (SAMPLE_FIFO_DEPTH)
  ) i_fifo (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .push_data     (push_data),
    .pop           (pop),
    .head          (head),
    .empty         (empty),
    .credit_return (credit_return)
  );

  // Host side
  sample_publisher i_publisher (
    .clk          (clk),
    .rst          (rst),
    .head         (head),
    .empty        (empty),
    .pop          (pop),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready)
  );

endmodule

// File: verification/expected_sample.svh
//~~~~~~~~~~~~~~~~~~~~
// Reference accelerometer reading for burst or sample n
// Included inside a module body after the imu_pkg import
// Axes wrap to 16 bits
//~~~~~~~~~~~~~~~~~~~~

// x = 3n - 100, y = -7n, z = n + 0x4000
function automatic imu_pkg::acc_sample_t expected_sample(input int n);
  imu_pkg::acc_sample_t s;
  s.x = 16'(n * 3 - 100);
  s.y = 16'(-n * 7);
  s.z = 16'(n + 32'h4000);
  return s;
endfunction

// File: verification/imu_spi_model.sv
//~~~~~~~~~~~~~~~~~~~~
// Behavioural SPI mode 0 sensor slave
// Identity reads return 0x71, bursts come from expected_sample
// Only the first register write is kept, all are counted
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module imu_spi_model (
  input  logic       ss,
  input  logic       sclk,
  input  logic       mosi,
  output logic       miso,
  output int         write_count,
  output logic [7:0] wr_addr,
  output logic [7:0] wr_data,
  output int         burst_count
);

  import imu_pkg::*;

  `include "expected_sample.svh"

  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic [7:0] addr;
  int         bit_cnt;
  int         byte_idx;
  int         cur_burst;

  // Reply byte for position idx of the current frame
  function automatic logic [7:0] read_byte(input int idx);
    acc_raw_t raw;
    raw = acc_raw_t'(expected_sample(cur_burst));
    if (!addr[7] || idx == 0) begin
      return 8'h00;
    end
    if (addr[6:0] == REG_WHO_AM_I[6:0]) begin
      return 8'h71;
    end
    // High byte of x goes out first
    if (addr[6:0] == REG_ACC_XOUT_H[6:0] && idx <= ACC_BURST_BYTES) begin
      return raw[ACC_BURST_BYTES - idx];
    end
    return 8'h00;
  endfunction

  initial begin
    miso        = 1'b0;
    write_count = 0;
    burst_count = 0;
    wr_addr     = '0;
    wr_data     = '0;
    addr        = '0;
    tx_shift    = '0;
    bit_cnt     = 0;
    byte_idx    = 0;
    cur_burst   = 0;
  end

  // New frame
  always @(negedge ss) begin
    bit_cnt  = 0;
    byte_idx = 0;
    tx_shift = '0;
    miso     = 1'b0;
  end

  // MOSI sampled on rising SCLK
  always @(posedge sclk) begin
    rx_shift = {rx_shift[6:0], mosi};
    bit_cnt  = bit_cnt + 1;
    if (bit_cnt == 8) begin
      bit_cnt = 0;
      if (byte_idx == 0) begin
        addr = rx_shift;
        // Each burst address opens the next reference sample
        if (addr == {SPI_READ_BIT, REG_ACC_XOUT_H[6:0]}) begin
          cur_burst   = burst_count;
          burst_count = burst_count + 1;
        end
      end else if (byte_idx == 1 && !addr[7]) begin
        if (write_count == 0) begin
          wr_addr = addr;
          wr_data = rx_shift;
        end
        write_count = write_count + 1;
      end
      byte_idx = byte_idx + 1;
    end
  end

  // MISO changes on falling SCLK, next byte loads at a boundary
  always @(negedge sclk) begin
    if (bit_cnt == 0) begin
      tx_shift = read_byte(byte_idx);
    end else begin
      tx_shift = {tx_shift[6:0], 1'b0};
    end
    miso = tx_shift[7];
  end

endmodule

// File: verification/sample_checker.sv
//~~~~~~~~~~~~~~~~~~~~
// Watches the reader ports and the sensor model
// Samples are numbered from 0 in delivery order
// Outputs are sampled on the rising clock edge
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sample_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  imu_pkg::acc_sample_t  sample,
  input  logic                  sample_valid,
  input  logic                  sample_ready,
  input  logic [7:0]            imu_id,
  input  logic                  id_valid,
  input  logic                  imu_ss,
  input  int                    write_count,
  input  logic [7:0]            wr_addr,
  input  logic [7:0]            wr_data,
  input  int                    burst_count,
  output int                    delivered,
  output int                    errors
);

  import imu_pkg::*;

  `include "expected_sample.svh"

  logic        was_rst;
  logic        id_seen;
  logic        held;
  logic        overrun_seen;
  acc_sample_t held_sample;
  acc_sample_t want;

  task automatic report_mismatch(input string name, input logic [47:0] expected,
                                 input logic [47:0] actual);
    $display("mismatch %s expected %0h actual %0h", name, expected, actual);
    errors = errors + 1;
  endtask

  initial begin
    delivered    = 0;
    errors       = 0;
    was_rst      = 1'b0;
    id_seen      = 1'b0;
    held         = 1'b0;
    overrun_seen = 1'b0;
    held_sample  = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      was_rst = 1'b1;
    end else begin
      // First cycle out of reset
      if (was_rst) begin
        was_rst = 1'b0;
        if (imu_ss !== 1'b1 || sample_valid !== 1'b0 || id_valid !== 1'b0) begin
          $display("outputs not at reset values: ss %b valid %b id_valid %b",
                   imu_ss, sample_valid, id_valid);
          errors = errors + 1;
        end
      end
      // Identity and configuration write
      if (id_valid === 1'b1 && !id_seen) begin
        id_seen = 1'b1;
        if (imu_id !== 8'h71) begin
          report_mismatch("identity", 48'h71, 48'(imu_id));
        end
        if (write_count != 1) begin
          $display("expected one register write before the reads, saw %0d", write_count);
          errors = errors + 1;
        end
        if (wr_addr !== REG_ACC_CONFIG) begin
          report_mismatch("config_address", 48'(REG_ACC_CONFIG), 48'(wr_addr));
        end
        if (wr_data !== ACC_CONFIG_VALUE) begin
          report_mismatch("config_value", 48'(ACC_CONFIG_VALUE), 48'(wr_data));
        end
      end
      // Stalled output must not move
      if (held && sample_valid !== 1'b1) begin
        $display("sample_valid dropped while the host was stalling");
        errors = errors + 1;
      end else if (held && sample !== held_sample) begin
        report_mismatch("stall_hold", held_sample, sample);
      end
      if (sample_valid === 1'b1 && sample_ready === 1'b1) begin
        want = expected_sample(delivered);
        if (sample !== want) begin
          report_mismatch($sformatf("sample_%0d", delivered), want, sample);
        end
        delivered = delivered + 1;
      end
      held        = (sample_valid === 1'b1) && (sample_ready === 1'b0);
      held_sample = sample;
      // Buffer plus output register bound the bursts ahead of the host
      if (burst_count - delivered > SAMPLE_FIFO_DEPTH + 1 && !overrun_seen) begin
        overrun_seen = 1'b1;
        $display("sensor saw %0d bursts with only %0d samples delivered",
                 burst_count, delivered);
        errors = errors + 1;
      end
    end
  end

endmodule

// File: verification/tb_imu_reader.sv
//~~~~~~~~~~~~~~~~~~~~
// Testbench for the accelerometer reader
// Short power-up counts, 20 ns clock, inputs change on falling edges
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_imu_reader;

  import imu_pkg::*;

  localparam int TICK_PERIOD = 50;

  logic        clk = 1'b0;
  logic        rst;
  logic        sample_tick = 1'b0;
  logic        sample_ready;
  logic        imu_miso;
  logic        imu_mosi;
  logic        imu_sclk;
  logic        imu_ss;
  acc_sample_t sample;
  logic        sample_valid;
  logic [7:0]  imu_id;
  logic        id_valid;
  logic [7:0]  wr_addr;
  logic [7:0]  wr_data;
  int          write_count;
  int          burst_count;
  int          delivered;
  int          errors;
  int          timeouts;
  int          tick_cnt = 0;

  always #10 clk = ~clk;

  imu_reader #(
    .WARMUP_CYCLES (20),
    .LOAD_CYCLES   (10),
    .HOLD_CYCLES   (4)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .sample_tick  (sample_tick),
    .imu_miso     (imu_miso),
    .imu_mosi     (imu_mosi),
    .imu_sclk     (imu_sclk),
    .imu_ss       (imu_ss),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .imu_id       (imu_id),
    .id_valid     (id_valid)
  );

  imu_spi_model i_model (
    .ss          (imu_ss),
    .sclk        (imu_sclk),
    .mosi        (imu_mosi),
    .miso        (imu_miso),
    .write_count (write_count),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .burst_count (burst_count)
  );

  sample_checker i_checker (
    .clk          (clk),
    .rst          (rst),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .imu_id       (imu_id),
    .id_valid     (id_valid),
    .imu_ss       (imu_ss),
    .write_count  (write_count),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .burst_count  (burst_count),
    .delivered    (delivered),
    .errors       (errors)
  );

  // One-cycle tick every TICK_PERIOD cycles
  always @(negedge clk) begin
    if (rst) begin
      tick_cnt    = 0;
      sample_tick = 1'b0;
    end else begin
      tick_cnt    = (tick_cnt == TICK_PERIOD - 1) ? 0 : tick_cnt + 1;
      sample_tick = (tick_cnt == 0);
    end
  end

  task automatic wait_for_id(input int limit);
    int cycles;
    cycles = 0;
    while (id_valid !== 1'b1 && cycles < limit && timeouts == 0) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= limit) begin
      $display("timeout: identity read did not complete in %0d cycles", limit);
      timeouts++;
    end
  endtask

  // Optionally toggles the host ready at random while waiting
  task automatic wait_for_samples(input int target, input int limit, input bit random_ready);
    int cycles;
    cycles = 0;
    while (delivered < target && cycles < limit && timeouts == 0) begin
      @(negedge clk);
      if (random_ready) begin
        sample_ready = 1'($urandom);
      end
      cycles++;
    end
    if (cycles >= limit) begin
      $display("timeout: %0d of %0d samples delivered", delivered, target);
      timeouts++;
    end
  endtask

  initial begin
    void'($urandom(35758));
    rst          = 1'b1;
    sample_ready = 1'b1;
    timeouts     = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    wait_for_id(5000);
    // Free-running host
    wait_for_samples(8, 20000, 1'b0);
    // Host stalls long enough to use up every credit
    @(negedge clk);
    sample_ready = 1'b0;
    repeat (6000) @(negedge clk);
    sample_ready = 1'b1;
    wait_for_samples(delivered + 12, 20000, 1'b0);
    // Random back-pressure
    wait_for_samples(delivered + 16, 40000, 1'b1);
    sample_ready = 1'b1;
    repeat (4) @(negedge clk);
    $display("checker errors: %0d, timeouts: %0d, samples checked: %0d, bursts read: %0d",
             errors, timeouts, delivered, burst_count);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: imu_reader.f
+incdir+verification
src/imu_pkg.sv
src/spi_byte_master.sv
src/imu_sequencer.sv
src/sample_fifo.sv
src/sample_publisher.sv
src/imu_reader.sv
verification/imu_spi_model.sv
verification/sample_checker.sv
verification/tb_imu_reader.sv

// File: Makefile
# Verilator flow for the accelerometer reader
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_imu_reader
RTL_TOP   ?= imu_reader
FILELIST  ?= imu_reader.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
sim: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
